// ==== flist.f ====
+incdir+common
+incdir+bench
common/backend_pkg.sv
verilog/issue_ctrl.sv
verilog/reg_file.sv
backend_pipe/alu_unit.sv
backend_pipe/exec_pipe.sv
verilog/backend.sv
bench/backend_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := backend_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/backend_ref_model.svh ====
`ifndef BACKEND_REF_MODEL_SVH
`define BACKEND_REF_MODEL_SVH

	localparam int PROG_LEN = 400;
	localparam int SEED_LEN = 8; // leading addi that load registers

	logic [31:0] rng_state;
	inst_t prog [0:PROG_LEN-1];
	commit_t exp_q [$]; // expected commits in program order

	// 32-bit xorshift with shifts 13, 17, 5
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	// architectural result of one instruction
	function automatic logic [31:0] model_op(inst_t in, logic [31:0] a, logic [31:0] b);
		logic [31:0] imm_ext;
		imm_ext = {{20{in.imm[11]}}, in.imm};
		case (in.op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SLT:  return {31'd0, $signed(a) < $signed(b)};
			OP_ADDI: return a + imm_ext;
			default: return a * b; // mul keeps the low word
		endcase
	endfunction

	task automatic gen_program();
		logic [31:0] r;
		inst_t in;
		rng_state = 32'd65;
		for (int i = 0; i < PROG_LEN; i++) begin
			r = next_rand();
			in = '0;
			in.imm = r[11:0];
			in.pc = 32'h0000_1000 + 32'(4 * i);
			if (i < SEED_LEN) begin
				in.op = OP_ADDI;
				in.rd = 5'(i); // rs1 stays x0
			end else begin
				// x0..x7 only, so dependences are dense
				in.rd = {2'b00, r[14:12]};
				in.rs1 = {2'b00, r[17:15]};
				in.rs2 = {2'b00, r[20:18]};
				r = next_rand();
				if (r % 100 < 15) begin
					in.op = OP_MUL;
				end else begin
					in.op = op_e'(3'(r[15:8] % 8'd7));
				end
			end
			prog[i] = in;
		end
	endtask

	// run the program in order and queue what should commit
	task automatic build_expected();
		logic [31:0] regs [0:31];
		logic [31:0] res;
		commit_t c;
		for (int r = 0; r < 32; r++) begin
			regs[r] = '0;
		end
		exp_q.delete();
		for (int i = 0; i < PROG_LEN; i++) begin
			res = model_op(prog[i], regs[prog[i].rs1], regs[prog[i].rs2]);
			if (prog[i].rd != 5'd0) begin
				regs[prog[i].rd] = res; // x0 commits but stays zero
			end
			c = '0;
			c.valid = 1'b1;
			c.rd = prog[i].rd;
			c.result = res;
			c.pc = prog[i].pc;
			exp_q.push_back(c);
		end
	endtask

`endif

// ==== bench/backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend_tb;

	import backend_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic rst_i;
	inst_t [1:0] inst_in;
	logic [1:0] inst_valid;
	logic [1:0] issue_num;
	commit_t [1:0] commit;

	int errors;
	int checks;
	int head; // next unissued instruction
	int committed;
	int revert_seen;

	`include "backend_ref_model.svh"

	backend backend_inst (
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_i       (inst_in),
		.inst_valid_i (inst_valid),
		.issue_num_o  (issue_num),
		.commit_o     (commit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED at time %0t: %s got 0x%0h, expected 0x%0h",
				$time, name, got, exp);
		end
	endtask

	task automatic check_limit(int got, int limit);
		checks++;
		assert (got <= limit) else begin
			errors++;
			$display("CHECK FAILED at time %0t: issue_num_o got %0d, limit %0d",
				$time, got, limit);
		end
	endtask

	// nothing issues and nothing commits
	task automatic check_idle();
		check_value("issue_num_o", 32'(issue_num), 32'd0);
		check_value("commit_o[0].valid", 32'(commit[0].valid), 32'd0);
		check_value("commit_o[1].valid", 32'(commit[1].valid), 32'd0);
	endtask

	// front end shows its two oldest instructions
	task automatic drive_front();
		inst_in = '0;
		inst_valid = 2'b00;
		if (head < PROG_LEN) begin
			inst_in[0] = prog[head];
			inst_valid[0] = 1'b1;
		end
		if (head + 1 < PROG_LEN) begin
			inst_in[1] = prog[head + 1];
			inst_valid[1] = 1'b1;
		end
	endtask

	// most instructions the pairing rule allows out of this group
	function automatic int pair_limit(inst_t older, inst_t younger, logic [1:0] valid);
		logic reads_rd;
		if (!valid[0]) begin
			return 0;
		end
		if (!valid[1]) begin
			return 1;
		end
		reads_rd = older.rd != 5'd0 && (younger.rs1 == older.rd ||
			(younger.op != OP_ADDI && younger.rs2 == older.rd)); // addi reads rs1 only
		if (reads_rd || (older.op == OP_MUL && younger.op == OP_MUL)) begin
			return 1;
		end
		return 2;
	endfunction

	task automatic check_commits();
		int first;
		int idx;
		int seen;
		commit_t exp;
		// the older record of a pair goes first
		first = (commit[0].valid && commit[1].valid && commit[0].younger) ? 1 : 0;
		seen = 0;
		for (int k = 0; k < 2; k++) begin
			idx = (k == 0) ? first : 1 - first;
			if (commit[idx].valid) begin
				// only the second record of a cycle is the younger one
				check_value($sformatf("commit_o[%0d].younger", idx),
					32'(commit[idx].younger), 32'(seen));
				seen++;
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("ERROR: commit of pc 0x%0h after the whole program committed",
						commit[idx].pc);
				end
				if (exp_q.size() != 0) begin
					exp = exp_q.pop_front();
					check_value($sformatf("commit_o[%0d].pc", idx), commit[idx].pc, exp.pc);
					check_value($sformatf("commit_o[%0d].rd", idx), 32'(commit[idx].rd),
						32'(exp.rd));
					check_value($sformatf("commit_o[%0d].result", idx), commit[idx].result,
						exp.result);
					committed++;
				end
			end
		end
	endtask

	initial begin
		int num;
		int cycles;
		logic mul_issued;
		errors = 0;
		checks = 0;
		head = 0;
		committed = 0;
		revert_seen = 0;
		mul_issued = 1'b0;
		rst_i = 1'b1;
		inst_in = '0;
		inst_valid = 2'b00;
		gen_program();
		build_expected();

		repeat (5) begin
			@(posedge clk);
			#1;
			check_idle();
		end
		rst_i = 1'b0;
		drive_front();

		cycles = 0;
		while (committed < PROG_LEN && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			if (cycles == 0) begin
				check_idle(); // ready flag still low
			end
			check_limit(int'(issue_num), pair_limit(inst_in[0], inst_in[1], inst_valid));
			if (mul_issued) begin
				check_value("issue_num_o", 32'(issue_num), 32'd0); // mul stall cycle
			end
			num = int'(issue_num);
			mul_issued = (num >= 1 && prog[head].op == OP_MUL) ||
				(num == 2 && prog[head + 1].op == OP_MUL);
			if (num == 2 && prog[head].op != OP_MUL && prog[head + 1].op == OP_MUL) begin
				revert_seen++; // alu then mul swaps pipes
			end
			check_commits();
			cycles++;
			@(posedge clk);
			#1;
			head += num;
			drive_front();
		end

		assert (committed == PROG_LEN) else begin
			errors++;
			$display("ERROR: timeout after %0d cycles, %0d of %0d instructions committed",
				cycles, committed, PROG_LEN);
		end
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("ERROR: %0d expected commits never arrived", exp_q.size());
		end
		assert (revert_seen > 0) else begin
			errors++;
			$display("ERROR: no ALU then multiply pair was issued");
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/backend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module backend (
	input  wire logic                        clk,
	input  wire logic                        rst_i,
	input  wire backend_pkg::inst_t [1:0]    inst_i,       // older in slot 0
	input  wire logic [1:0]                  inst_valid_i,
	output logic [1:0]                       issue_num_o,  // 0, 1 or 2
	output backend_pkg::commit_t [1:0]       commit_o
);

	import backend_pkg::*;

	issue_slot_t [1:0] slot;    // indexed by pipe
	ex_info_t [1:0] ex_info;
	logic [3:0][4:0] rd_addr;
	logic [3:0][`DATA_W-1:0] rd_data;
	logic stall;
	logic mul_stall_req;

	issue_ctrl issue_ctrl_inst (
		.clk            (clk),
		.rst_i          (rst_i),
		.inst_i         (inst_i),
		.inst_valid_i   (inst_valid_i),
		.ex_info_i      (ex_info),
		.ex_stall_req_i (mul_stall_req),
		.issue_num_o    (issue_num_o),
		.slot_o         (slot),
		.rd_addr_o      (rd_addr),
		.stall_o        (stall)
	);

	// WB records are the write ports
	reg_file reg_file_inst (
		.clk       (clk),
		.rst_i     (rst_i),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data),
		.wr_i      (commit_o)
	);

	exec_pipe #(
		.MAIN_PIPE (1'b1)
	) pipe_main (
		.clk            (clk),
		.rst_i          (rst_i),
		.slot_i         (slot[0]),
		.rd_data_i      (rd_data[1:0]),
		.ex_fwd_i       (ex_info),
		.stall_i        (stall),
		.ex_info_o      (ex_info[0]),
		.ex_stall_req_o (mul_stall_req),
		.commit_o       (commit_o[0])
	);

	// no multiplier, never asks for a stall
	exec_pipe #(
		.MAIN_PIPE (1'b0)
	) pipe_sub (
		.clk            (clk),
		.rst_i          (rst_i),
		.slot_i         (slot[1]),
		.rd_data_i      (rd_data[3:2]),
		.ex_fwd_i       (ex_info),
		.stall_i        (stall),
		.ex_info_o      (ex_info[1]),
		.ex_stall_req_o (),
		.commit_o       (commit_o[1])
	);

endmodule

`default_nettype wire

// ==== backend_pipe/exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module exec_pipe #(
	parameter bit MAIN_PIPE = 1'b0 // main pipe owns the multiplier
) (
	input  wire logic                          clk,
	input  wire logic                          rst_i,
	input  wire backend_pkg::issue_slot_t      slot_i,
	input  wire logic [1:0][`DATA_W-1:0]       rd_data_i,
	input  wire backend_pkg::ex_info_t [1:0]   ex_fwd_i,
	input  wire logic                          stall_i,
	output backend_pkg::ex_info_t              ex_info_o,
	output logic                               ex_stall_req_o,
	output backend_pkg::commit_t               commit_o
);

	import backend_pkg::*;

	logic [1:0][`DATA_W-1:0] opnd;

	// EX stage
	logic ex_valid_q;
	logic ex_younger_q;
	inst_t ex_inst_q;
	logic [1:0][`DATA_W-1:0] ex_opnd_q;

	logic [`DATA_W-1:0] alu_result;
	logic mul_start;
	logic mul_busy;

	commit_t wb_q;

	// operand select at issue
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			case (slot_i.fwd[k])
				FWD_EX0: opnd[k] = ex_fwd_i[0].result;
				FWD_EX1: opnd[k] = ex_fwd_i[1].result;
				default: opnd[k] = rd_data_i[k];
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ex_valid_q <= 1'b0;
		end else if (!stall_i) begin
			ex_valid_q <= slot_i.valid;
		end
		if (!stall_i) begin
			ex_younger_q <= slot_i.younger;
			ex_inst_q <= slot_i.inst;
			ex_opnd_q <= opnd;
		end
	end

	assign mul_start = MAIN_PIPE && ex_valid_q && ex_inst_q.op == OP_MUL;

	alu_unit alu_inst (
		.clk      (clk),
		.rst_i    (rst_i),
		.op_i     (ex_inst_q.op),
		.a_i      (ex_opnd_q[0]),
		.b_i      (ex_opnd_q[1]),
		.imm_i    (ex_inst_q.imm),
		.start_i  (mul_start),
		.hold_i   (stall_i),
		.result_o (alu_result),
		.busy_o   (mul_busy)
	);

	assign ex_stall_req_o = MAIN_PIPE ? mul_busy : 1'b0;

	always_comb begin
		ex_info_o.valid = ex_valid_q;
		ex_info_o.younger = ex_younger_q;
		ex_info_o.rd = ex_inst_q.rd;
		ex_info_o.result = alu_result;
	end

	// WB takes a bubble while EX is held
	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb_q.valid <= 1'b0;
		end else begin
			wb_q.valid <= ex_valid_q && !stall_i;
		end
		wb_q.younger <= ex_younger_q;
		wb_q.rd <= ex_inst_q.rd;
		wb_q.result <= alu_result;
		wb_q.pc <= ex_inst_q.pc;
	end

	assign commit_o = wb_q;

endmodule

`default_nettype wire

// ==== backend_pipe/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module alu_unit (
	input  wire logic                  clk,
	input  wire logic                  rst_i,
	input  wire backend_pkg::op_e      op_i,
	input  wire logic [`DATA_W-1:0]    a_i,
	input  wire logic [`DATA_W-1:0]    b_i,
	input  wire logic [11:0]           imm_i,
	input  wire logic                  start_i, // mul sitting in EX
	input  wire logic                  hold_i,  // EX not advancing
	output logic [`DATA_W-1:0]         result_o,
	output logic                       busy_o
);

	import backend_pkg::*;

	localparam int CNT_W = $clog2(`MUL_CYCLES);

	logic [CNT_W-1:0] mul_cnt_q;
	logic [`DATA_W-1:0] prod_q;
	logic [`DATA_W-1:0] imm_ext;

	assign imm_ext = {{(`DATA_W - 12){imm_i[11]}}, imm_i};
	assign busy_o = start_i && mul_cnt_q != CNT_W'(`MUL_CYCLES - 1);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mul_cnt_q <= '0;
		end else if (busy_o) begin
			mul_cnt_q <= mul_cnt_q + 1'b1;
		end else if (!hold_i) begin
			mul_cnt_q <= '0; // ready for the next mul
		end
	end

	// low half of the product only
	always_ff @(posedge clk) begin
		if (start_i && mul_cnt_q == '0) begin
			prod_q <= a_i * b_i;
		end
	end

	always_comb begin
		result_o = '0;
		case (op_i)
			OP_ADD:  result_o = a_i + b_i;
			OP_SUB:  result_o = a_i - b_i;
			OP_AND:  result_o = a_i & b_i;
			OP_OR:   result_o = a_i | b_i;
			OP_XOR:  result_o = a_i ^ b_i;
			OP_SLT:  result_o[0] = $signed(a_i) < $signed(b_i);
			OP_ADDI: result_o = a_i + imm_ext;
			OP_MUL:  result_o = prod_q; // valid once busy drops
			default: result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module reg_file (
	input  wire logic                         clk,
	input  wire logic                         rst_i,
	input  wire logic [3:0][4:0]              rd_addr_i,
	output logic [3:0][`DATA_W-1:0]           rd_data_o,
	input  wire backend_pkg::commit_t [1:0]   wr_i
);

	logic [`DATA_W-1:0] regs [1:`REG_NUM-1]; // x0 is not stored
	logic [1:0] wr_en;

	// drop the older write when both hit the same rd
	always_comb begin
		for (int p = 0; p < 2; p++) begin
			wr_en[p] = wr_i[p].valid && wr_i[p].rd != '0 &&
				!(wr_i[1 - p].valid && wr_i[1 - p].rd == wr_i[p].rd && wr_i[1 - p].younger);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int r = 1; r < `REG_NUM; r++) begin
				regs[r] <= '0; // architectural state starts at zero
			end
		end else begin
			for (int p = 0; p < 2; p++) begin
				if (wr_en[p]) begin
					regs[wr_i[p].rd] <= wr_i[p].result;
				end
			end
		end
	end

	// read with bypass of this cycle's writes
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (rd_addr_i[i] == '0) begin
				rd_data_o[i] = '0;
			end else if (wr_en[1] && wr_i[1].rd == rd_addr_i[i]) begin
				rd_data_o[i] = wr_i[1].result;
			end else if (wr_en[0] && wr_i[0].rd == rd_addr_i[i]) begin
				rd_data_o[i] = wr_i[0].result;
			end else begin
				rd_data_o[i] = regs[rd_addr_i[i]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_consts.svh"

module issue_ctrl (
	input  wire logic                          clk,
	input  wire logic                          rst_i,
	input  wire backend_pkg::inst_t [1:0]      inst_i,
	input  wire logic [1:0]                    inst_valid_i,
	input  wire backend_pkg::ex_info_t [1:0]   ex_info_i,
	input  wire logic                          ex_stall_req_i,
	output logic [1:0]                         issue_num_o,
	output backend_pkg::issue_slot_t [1:0]     slot_o,
	output logic [3:0][4:0]                    rd_addr_o,
	output logic                               stall_o
);

	import backend_pkg::*;

	logic ready_q; // low through reset and one cycle after
	logic dep;
	logic both_mul;
	logic issue_one;
	logic issue_two;
	logic revert;

	// EX stage that produces src, younger one wins a double hit
	function automatic fwd_sel_e pick_fwd(logic [4:0] src, ex_info_t [1:0] ex);
		logic hit0;
		logic hit1;
		hit0 = ex[0].valid && ex[0].rd != '0 && ex[0].rd == src;
		hit1 = ex[1].valid && ex[1].rd != '0 && ex[1].rd == src;
		if (hit0 && hit1) begin
			return ex[1].younger ? FWD_EX1 : FWD_EX0;
		end
		if (hit0) begin
			return FWD_EX0;
		end
		if (hit1) begin
			return FWD_EX1;
		end
		return FWD_REG;
	endfunction

	always_ff @(posedge clk) begin
		if (rst_i) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= 1'b1;
		end
	end

	// pairing rules
	always_comb begin
		dep = inst_i[0].rd != '0 &&
			(inst_i[1].rs1 == inst_i[0].rd ||
			(inst_i[1].op != OP_ADDI && inst_i[1].rs2 == inst_i[0].rd)); // addi has no rs2
		both_mul = inst_i[0].op == OP_MUL && inst_i[1].op == OP_MUL;
		issue_one = ready_q && !ex_stall_req_i && inst_valid_i[0];
		issue_two = issue_one && inst_valid_i[1] && !dep && !both_mul;
		// only pipe 0 multiplies, so alu then mul swaps pipes
		revert = issue_two && inst_i[0].op != OP_MUL && inst_i[1].op == OP_MUL;
	end

	assign issue_num_o = issue_two ? 2'd2 : (issue_one ? 2'd1 : 2'd0);
	assign stall_o = ex_stall_req_i; // one stall source for now

	always_comb begin
		inst_t sel;
		for (int p = 0; p < 2; p++) begin
			sel = revert ? inst_i[1 - p] : inst_i[p];
			slot_o[p].inst = sel;
			slot_o[p].valid = (p == 0) ? issue_one : issue_two;
			if (p == 0) begin
				slot_o[p].younger = revert;
			end else begin
				slot_o[p].younger = issue_two && !revert;
			end
			slot_o[p].fwd[0] = pick_fwd(sel.rs1, ex_info_i);
			slot_o[p].fwd[1] = pick_fwd(sel.rs2, ex_info_i);
			rd_addr_o[2 * p] = sel.rs1;
			rd_addr_o[2 * p + 1] = sel.rs2;
		end
	end

endmodule

`default_nettype wire

// ==== common/backend_pkg.sv ====
`default_nettype none

`include "backend_consts.svh"

package backend_pkg;

	// decoded opcodes, OP_ADDI is the only one using imm
	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_ADDI,
		OP_MUL
	} op_e;

	typedef struct packed {
		op_e                op;
		logic [4:0]         rd;
		logic [4:0]         rs1;
		logic [4:0]         rs2;
		logic [11:0]        imm; // sign extended in the ALU
		logic [`DATA_W-1:0] pc;
	} inst_t;

	// where an operand comes from at issue
	typedef enum logic [1:0] {
		FWD_REG,
		FWD_EX0,
		FWD_EX1
	} fwd_sel_e;

	// one pipe's share of the issue group
	typedef struct packed {
		logic                 valid;
		logic                 younger; // second in program order of a pair
		inst_t                inst;
		fwd_sel_e [1:0]       fwd;     // [0] rs1, [1] rs2
	} issue_slot_t;

	typedef struct packed {
		logic               valid;
		logic               younger;
		logic [4:0]         rd;
		logic [`DATA_W-1:0] result;
	} ex_info_t;

	// WB record, doubles as regfile write port
	typedef struct packed {
		logic               valid;
		logic               younger;
		logic [4:0]         rd;
		logic [`DATA_W-1:0] result;
		logic [`DATA_W-1:0] pc;
	} commit_t;

endpackage

`default_nettype wire

// ==== common/backend_consts.svh ====
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data path and register file sizing
`define DATA_W 32
`define REG_NUM 32

// EX cycles taken by a multiply, busy for all but the last
`define MUL_CYCLES 2

`endif
